/* rtl/recoveryPkg.sv */
// Recovery types shared by the scheduler wakeup path
// Active-list pointers, recovery requests from the recovery manager
// and the latched selective-flush window with its range check

package recoveryPkg;

    // Active-list geometry
    localparam int activeListEntries = 64;

    typedef logic [$clog2(activeListEntries)-1:0] activeListPtrT;

    // Recovery request, toRecovery is a one-cycle strobe
    typedef struct packed {
        logic          toRecovery;
        logic          fromRwStage;
        activeListPtrT headPtr;
        activeListPtrT tailPtr;
        logic          flushAll;
    } recoveryReqT;

    // Range of active-list entries being flushed selectively
    typedef struct packed {
        activeListPtrT headPtr;
        activeListPtrT tailPtr;
        logic          flushAll;
    } flushWindowT;

    // True when ptr lies in [headPtr, tailPtr) on the circular list
    // An equal head and tail means nothing is in range
    function automatic logic inFlushRange(flushWindowT window, activeListPtrT ptr);
        logic hit;
        if (window.flushAll) begin
            hit = 1'b1;
        end else if (window.headPtr <= window.tailPtr) begin
            hit = (ptr >= window.headPtr) && (ptr < window.tailPtr);
        end else begin
            // Range wraps past the end of the list
            hit = (ptr >= window.headPtr) || (ptr < window.tailPtr);
        end
        return hit;
    endfunction

endpackage

/* rtl/schedPkg.sv */
// Scheduler types for the issue queue and its wakeup path
// Slot indices, dependency vectors and the records that travel
// from select logic through the wakeup pipeline back to the queue

package schedPkg;

    // Issue-queue geometry
    localparam int iqEntries = 16;

    typedef logic [$clog2(iqEntries)-1:0] iqIndexT;
    typedef logic [iqEntries-1:0]         iqOneHotT;

    // One granted entry from the select logic
    typedef struct packed {
        logic                       valid;
        iqIndexT                    iqPtr;
        // Consumers that depend on this producer
        iqOneHotT                   depVector;
        recoveryPkg::activeListPtrT alPtr;
    } issueSelectT;

    // Wakeup toward the producer matrix
    typedef struct packed {
        logic     valid;
        iqIndexT  iqPtr;
        iqOneHotT depVector;
    } wakeupT;

    // Slot release toward the issue queue
    typedef struct packed {
        logic    valid;
        iqIndexT iqPtr;
    } releaseT;

endpackage

/* rtl/flushWindowTracker.sv */
// Selective-flush window tracker
// Latches the active-list range of a recovery from the register-write
// stage and counts, per lane class, how many cycles flushed ops may
// still sit in the wakeup pipeline

`timescale 1ns/1ns

module flushWindowTracker #(
    parameter int MemLatency = 2
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,
    input  recoveryPkg::recoveryReqT   recoveryReq,
    output recoveryPkg::flushWindowT   window,
    output logic                       intWindowActive,
    output logic                       memWindowActive,
    output logic                       flushedOpExist
);

    // Integer lanes always have a single stage
    localparam int IntLatency = 1;
    localparam int IntCntW    = $clog2(IntLatency + 1);
    localparam int MemCntW    = $clog2(MemLatency + 1);

    logic               selRecovery;
    logic [IntCntW-1:0] intCount;
    logic [MemCntW-1:0] memCount;

    if (MemLatency < 2) begin : genLatencyCheck
        $error("Memory lanes need a latency of at least 2");
    end

    assign selRecovery = recoveryReq.toRecovery && recoveryReq.fromRwStage;

    // Flush range is only meaningful while a counter is running
    always_ff @(posedge clk) begin
        if (selRecovery) begin
            window.headPtr  <= recoveryReq.headPtr;
            window.tailPtr  <= recoveryReq.tailPtr;
            window.flushAll <= recoveryReq.flushAll;
        end
    end

    // A counter at its full value still covers the entry stage,
    // which only advances without a stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            intCount <= '0;
            memCount <= '0;
        end else if (selRecovery) begin
            intCount <= IntCntW'(IntLatency);
            memCount <= MemCntW'(MemLatency);
        end else begin
            if (intCount == IntCntW'(IntLatency)) begin
                if (!stall) begin
                    intCount <= intCount - 1'b1;
                end
            end else if (intCount != '0) begin
                intCount <= intCount - 1'b1;
            end

            if (memCount == MemCntW'(MemLatency)) begin
                if (!stall) begin
                    memCount <= memCount - 1'b1;
                end
            end else if (memCount != '0) begin
                memCount <= memCount - 1'b1;
            end
        end
    end

    assign intWindowActive = (intCount != '0);
    assign memWindowActive = (memCount != '0);
    assign flushedOpExist  = intWindowActive || memWindowActive;

    // Memory counter stays within the depth of the memory lanes
    counterBound: assert property (
        @(posedge clk) disable iff (!rstN)
        memCount <= MemCntW'(MemLatency)
    );

endmodule

/* rtl/wakeupLane.sv */
// Wakeup delay line for one issue lane
// Captures a granted entry, delays it by Latency cycles and then
// wakes up its consumers and releases its issue-queue slot
// Handles flushing slots, full and selective recovery and stall

`timescale 1ns/1ns

module wakeupLane #(
    parameter int Latency = 1
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     stall,
    input  schedPkg::issueSelectT    select,
    input  schedPkg::iqOneHotT       flushIqEntry,
    input  recoveryPkg::recoveryReqT recoveryReq,
    input  recoveryPkg::flushWindowT window,
    input  logic                     windowActive,
    output schedPkg::wakeupT         wakeup,
    output schedPkg::releaseT        releaseEntry
);

    import schedPkg::*;
    import recoveryPkg::*;

    // A single-stage lane cannot insert a bubble, so it gates instead
    localparam bit GateOnStall = (Latency == 1);

    // Stage Latency-1 takes new selections, stage 0 drives the outputs
    issueSelectT stage [Latency];
    issueSelectT entry;
    logic        fullFlush;
    logic        stallGate;
    logic        flushHit;

    if (Latency < 1) begin : genLatencyCheck
        $error("A wakeup lane needs at least one stage");
    end

    assign fullFlush = recoveryReq.toRecovery && !recoveryReq.fromRwStage;

    // Drop a grant whose slot is being flushed in the same cycle
    always_comb begin
        entry       = select;
        entry.valid = select.valid && !flushIqEntry[select.iqPtr];
    end

    for (genvar i = 0; i < Latency; i++) begin : genStage
        if (i == Latency - 1) begin : genEntry
            // Entry stage holds under stall
            always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                    stage[i] <= '0;
                end else if (fullFlush) begin
                    stage[i].valid <= 1'b0;
                end else if (!stall) begin
                    stage[i] <= entry;
                end
            end
        end else begin : genShift
            // Later stages keep moving, the one behind a held entry
            // takes a bubble
            always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                    stage[i] <= '0;
                end else if (fullFlush) begin
                    stage[i].valid <= 1'b0;
                end else if (stall && (i == Latency - 2)) begin
                    stage[i].valid     <= 1'b0;
                    stage[i].depVector <= '0;
                end else begin
                    stage[i] <= stage[i+1];
                end
            end
        end
    end

    assign stallGate = GateOnStall && stall;

    // Ops inside the selective-flush range must not wake consumers
    assign flushHit = windowActive && inFlushRange(window, stage[0].alPtr);

    always_comb begin
        wakeup.valid     = stage[0].valid && !flushHit && !stallGate;
        wakeup.iqPtr     = stage[0].iqPtr;
        wakeup.depVector = stallGate ? '0 : stage[0].depVector;
    end

    // The slot is freed even for a flushed op
    always_comb begin
        releaseEntry.valid = stage[0].valid && !stallGate;
        releaseEntry.iqPtr = stage[0].iqPtr;
    end

    // A grant with no stall or full flush on its way reaches the
    // outputs Latency cycles after it was taken
    laneLatency: assert property (
        @(posedge clk) disable iff (!rstN)
        (entry.valid && !stall && !fullFlush) ##1 (!stall && !fullFlush) [*Latency]
        |-> releaseEntry.valid && (releaseEntry.iqPtr == $past(entry.iqPtr, Latency))
    );

endmodule

/* rtl/wakeupPipelineRegister.sv */
// Wakeup pipeline register of the out-of-order scheduler
// Integer lanes come first in the select, wakeup and release arrays,
// memory lanes follow; one tracker bounds the selective-flush window

`timescale 1ns/1ns

module wakeupPipelineRegister #(
    parameter int IntIssueWidth = 2,
    parameter int MemIssueWidth = 1,
    parameter int MemLatency    = 2
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     stall,
    input  schedPkg::issueSelectT    select [IntIssueWidth + MemIssueWidth],
    input  schedPkg::iqOneHotT       flushIqEntry,
    input  recoveryPkg::recoveryReqT recoveryReq,
    output schedPkg::wakeupT         wakeup [IntIssueWidth + MemIssueWidth],
    output schedPkg::releaseT        releaseEntry [IntIssueWidth + MemIssueWidth],
    output logic                     flushedOpExist
);

    import recoveryPkg::*;

    flushWindowT window;
    logic        intWindowActive;
    logic        memWindowActive;

    flushWindowTracker #(
        .MemLatency(MemLatency)
    ) flushWindowTracker_inst (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .recoveryReq    (recoveryReq),
        .window         (window),
        .intWindowActive(intWindowActive),
        .memWindowActive(memWindowActive),
        .flushedOpExist (flushedOpExist)
    );

    for (genvar i = 0; i < IntIssueWidth; i++) begin : genIntLane
        wakeupLane #(
            .Latency(1)
        ) wakeupLane_inst (
            .clk         (clk),
            .rstN        (rstN),
            .stall       (stall),
            .select      (select[i]),
            .flushIqEntry(flushIqEntry),
            .recoveryReq (recoveryReq),
            .window      (window),
            .windowActive(intWindowActive),
            .wakeup      (wakeup[i]),
            .releaseEntry(releaseEntry[i])
        );
    end

    for (genvar i = 0; i < MemIssueWidth; i++) begin : genMemLane
        wakeupLane #(
            .Latency(MemLatency)
        ) wakeupLane_inst (
            .clk         (clk),
            .rstN        (rstN),
            .stall       (stall),
            .select      (select[IntIssueWidth + i]),
            .flushIqEntry(flushIqEntry),
            .recoveryReq (recoveryReq),
            .window      (window),
            .windowActive(memWindowActive),
            .wakeup      (wakeup[IntIssueWidth + i]),
            .releaseEntry(releaseEntry[IntIssueWidth + i])
        );
    end

endmodule

/* verif/tbClockGen.sv */
// Testbench clock and reset generator
// Free-running clock, reset held low for a fixed number of cycles
// and released on a falling edge

`timescale 1ns/1ns

module tbClockGen #(
    parameter int Period      = 20,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        // Release away from the rising edge
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* verif/wakeupPipelineRegisterTb.sv */
// Testbench for the wakeup pipeline register
// Builds a table of per-cycle stimulus with expected outputs, applies
// it row by row and checks wakeup, release and flushedOpExist

`timescale 1ns/1ns

module wakeupPipelineRegisterTb;

    import schedPkg::*;
    import recoveryPkg::*;

    localparam int ClkPeriod     = 20;
    localparam int IntIssueWidth = 2;
    localparam int MemIssueWidth = 1;
    localparam int MemLatency    = 2;
    localparam int Lanes         = IntIssueWidth + MemIssueWidth;
    localparam int MemLane       = IntIssueWidth;
    localparam int NumRows       = 40;
    localparam logic [15:0] LfsrSeed = 16'd26269;

    // One cycle of stimulus and the outputs expected in that cycle
    typedef struct packed {
        logic                    stall;
        issueSelectT [Lanes-1:0] select;
        iqOneHotT                flushIqEntry;
        recoveryReqT             recoveryReq;
        wakeupT [Lanes-1:0]      expWakeup;
        releaseT [Lanes-1:0]     expRelease;
        logic                    expFlushedOpExist;
    } stimRowT;

    logic        clk;
    logic        rstN;
    logic        stall;
    issueSelectT select [Lanes];
    iqOneHotT    flushIqEntry;
    recoveryReqT recoveryReq;
    wakeupT      wakeup [Lanes];
    releaseT     releaseEntry [Lanes];
    logic        flushedOpExist;

    stimRowT     tbl [NumRows];
    logic [15:0] lfsrState;
    int          checkCount;
    int          errorCount;

    tbClockGen #(
        .Period     (ClkPeriod),
        .ResetCycles(4)
    ) tbClockGen_inst (
        .clk (clk),
        .rstN(rstN)
    );

    wakeupPipelineRegister wakeupPipelineRegister_inst (
        .clk           (clk),
        .rstN          (rstN),
        .stall         (stall),
        .select        (select),
        .flushIqEntry  (flushIqEntry),
        .recoveryReq   (recoveryReq),
        .wakeup        (wakeup),
        .releaseEntry  (releaseEntry),
        .flushedOpExist(flushedOpExist)
    );

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int width);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < width; i++) begin
            bits[i]   = lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    function automatic activeListPtrT randomAlPtr();
        return activeListPtrT'(takeBits($bits(activeListPtrT)));
    endfunction

    // Pointer inside [head, head + len)
    function automatic activeListPtrT inRangePtr(input activeListPtrT head, input int len);
        return head + activeListPtrT'(takeBits(5) % len);
    endfunction

    // At most 31 past the tail, so never back inside a range of up to 32
    function automatic activeListPtrT outOfRangePtr(input activeListPtrT tail);
        return tail + activeListPtrT'(takeBits(5));
    endfunction

    function automatic issueSelectT makeSelect(input iqIndexT iqPtr, input activeListPtrT alPtr);
        issueSelectT sel;
        sel.valid     = 1'b1;
        sel.iqPtr     = iqPtr;
        sel.depVector = iqOneHotT'(takeBits(iqEntries));
        sel.alPtr     = alPtr;
        return sel;
    endfunction

    task automatic putSelect(input int rowIdx, input int lane, input issueSelectT sel);
        stimRowT r;
        r = tbl[rowIdx];
        r.select[lane] = sel;
        tbl[rowIdx] = r;
    endtask

    // A delivered op always releases its slot, wakes only when asked
    task automatic expectOutput(input int rowIdx, input int lane, input issueSelectT sel,
                                input logic wakes);
        stimRowT r;
        r = tbl[rowIdx];
        r.expWakeup[lane].valid     = wakes;
        r.expWakeup[lane].iqPtr     = sel.iqPtr;
        r.expWakeup[lane].depVector = sel.depVector;
        r.expRelease[lane].valid    = 1'b1;
        r.expRelease[lane].iqPtr    = sel.iqPtr;
        tbl[rowIdx] = r;
    endtask

    task automatic buildTable();
        issueSelectT   s0;
        issueSelectT   s1;
        issueSelectT   s2;
        issueSelectT   s3;
        recoveryReqT   req;
        activeListPtrT head;
        activeListPtrT tail;
        int            len;
        lfsrState = LfsrSeed;
        for (int i = 0; i < NumRows; i++) begin
            tbl[i] = '0;
        end

        // Integer lanes deliver one cycle later
        s0 = makeSelect(4'd3, randomAlPtr());
        s1 = makeSelect(4'd7, randomAlPtr());
        putSelect(0, 0, s0);
        putSelect(0, 1, s1);
        expectOutput(1, 0, s0, 1'b1);
        expectOutput(1, 1, s1, 1'b1);

        // Back-to-back memory ops, both in flight together
        s0 = makeSelect(4'd5, randomAlPtr());
        s1 = makeSelect(4'd9, randomAlPtr());
        putSelect(3, MemLane, s0);
        putSelect(4, MemLane, s1);
        expectOutput(3 + MemLatency, MemLane, s0, 1'b1);
        expectOutput(4 + MemLatency, MemLane, s1, 1'b1);

        // Slots 2 and 13 are being flushed
        s0 = makeSelect(4'd2, randomAlPtr());
        s1 = makeSelect(4'd4, randomAlPtr());
        s2 = makeSelect(4'd2, randomAlPtr());
        putSelect(8, 0, s0);
        putSelect(8, 1, s1);
        putSelect(8, MemLane, s2);
        tbl[8].flushIqEntry = iqOneHotT'(16'h2004);
        expectOutput(9, 1, s1, 1'b1);

        // Integer stall gates the outputs and drops the new grant
        s0 = makeSelect(4'd6, randomAlPtr());
        s1 = makeSelect(4'd11, randomAlPtr());
        putSelect(12, 0, s0);
        tbl[13].stall = 1'b1;
        putSelect(13, 1, s1);
        expectOutput(14, 0, s0, 1'b1);

        // Memory stall, the op in stage 0 still leaves, bubble behind it
        s0 = makeSelect(4'd1, randomAlPtr());
        s1 = makeSelect(4'd12, randomAlPtr());
        s2 = makeSelect(4'd14, randomAlPtr());
        putSelect(16, MemLane, s0);
        putSelect(17, MemLane, s1);
        tbl[18].stall = 1'b1;
        putSelect(18, MemLane, s2);
        expectOutput(18, MemLane, s0, 1'b1);
        expectOutput(20, MemLane, s1, 1'b1);

        // Full flush clears everything in flight
        s0 = makeSelect(4'd8, randomAlPtr());
        s1 = makeSelect(4'd10, randomAlPtr());
        s2 = makeSelect(4'd15, randomAlPtr());
        putSelect(23, 0, s0);
        putSelect(23, MemLane, s1);
        expectOutput(24, 0, s0, 1'b1);
        req            = '0;
        req.toRecovery = 1'b1;
        tbl[24].recoveryReq = req;
        putSelect(24, MemLane, s2);

        // Selective flush over a random range of 1 to 32 entries
        head = randomAlPtr();
        len  = 1 + int'(takeBits(5));
        tail = head + activeListPtrT'(len);
        s0 = makeSelect(4'd0, inRangePtr(head, len));
        s1 = makeSelect(4'd1, inRangePtr(head, len));
        s2 = makeSelect(4'd2, outOfRangePtr(tail));
        s3 = makeSelect(4'd3, outOfRangePtr(tail));
        putSelect(28, MemLane, s0);
        req             = '0;
        req.toRecovery  = 1'b1;
        req.fromRwStage = 1'b1;
        req.headPtr     = head;
        req.tailPtr     = tail;
        tbl[29].recoveryReq = req;
        putSelect(29, 0, s1);
        putSelect(29, 1, s2);
        putSelect(29, MemLane, s3);
        expectOutput(30, 0, s1, 1'b0);
        expectOutput(30, 1, s2, 1'b1);
        expectOutput(30, MemLane, s0, 1'b0);
        expectOutput(31, MemLane, s3, 1'b1);
        tbl[30].expFlushedOpExist = 1'b1;
        tbl[31].expFlushedOpExist = 1'b1;
        // Integer window is already closed when this one arrives
        s0 = makeSelect(4'd4, inRangePtr(head, len));
        putSelect(30, 0, s0);
        expectOutput(31, 0, s0, 1'b1);

        // Flush-all with an empty pointer range
        head = randomAlPtr();
        s0 = makeSelect(4'd5, randomAlPtr());
        s1 = makeSelect(4'd6, randomAlPtr());
        s2 = makeSelect(4'd7, randomAlPtr());
        putSelect(34, MemLane, s0);
        req             = '0;
        req.toRecovery  = 1'b1;
        req.fromRwStage = 1'b1;
        req.headPtr     = head;
        req.tailPtr     = head;
        req.flushAll    = 1'b1;
        tbl[35].recoveryReq = req;
        putSelect(35, 0, s1);
        putSelect(35, MemLane, s2);
        expectOutput(36, 0, s1, 1'b0);
        expectOutput(36, MemLane, s0, 1'b0);
        expectOutput(37, MemLane, s2, 1'b0);
        tbl[36].expFlushedOpExist = 1'b1;
        tbl[37].expFlushedOpExist = 1'b1;
    endtask

    task automatic applyRow(input int rowIdx);
        stall        = tbl[rowIdx].stall;
        flushIqEntry = tbl[rowIdx].flushIqEntry;
        recoveryReq  = tbl[rowIdx].recoveryReq;
        for (int l = 0; l < Lanes; l++) begin
            select[l] = tbl[rowIdx].select[l];
        end
    endtask

    task automatic checkField(input string what, input int rowIdx,
                              input logic [31:0] actual, input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR %0t: row %0d %s is %0h, expected %0h",
                     $time, rowIdx, what, actual, expected);
        end
    endtask

    task automatic checkRow(input int rowIdx);
        stimRowT r;
        r = tbl[rowIdx];
        for (int l = 0; l < Lanes; l++) begin
            checkField($sformatf("lane %0d wakeup.valid", l), rowIdx,
                       wakeup[l].valid, r.expWakeup[l].valid);
            if (r.expWakeup[l].valid) begin
                checkField($sformatf("lane %0d wakeup.iqPtr", l), rowIdx,
                           wakeup[l].iqPtr, r.expWakeup[l].iqPtr);
                checkField($sformatf("lane %0d wakeup.depVector", l), rowIdx,
                           wakeup[l].depVector, r.expWakeup[l].depVector);
            end
            // Stalled integer lanes drive no dependency vector
            if (r.stall && (l < IntIssueWidth)) begin
                checkField($sformatf("lane %0d gated depVector", l), rowIdx,
                           wakeup[l].depVector, '0);
            end
            checkField($sformatf("lane %0d release.valid", l), rowIdx,
                       releaseEntry[l].valid, r.expRelease[l].valid);
            if (r.expRelease[l].valid) begin
                checkField($sformatf("lane %0d release.iqPtr", l), rowIdx,
                           releaseEntry[l].iqPtr, r.expRelease[l].iqPtr);
            end
        end
        checkField("flushedOpExist", rowIdx, flushedOpExist, r.expFlushedOpExist);
    endtask

    // Drive on the falling edge, sample just before the rising edge
    initial begin
        stall        = 1'b0;
        flushIqEntry = '0;
        recoveryReq  = '0;
        for (int l = 0; l < Lanes; l++) begin
            select[l] = '0;
        end
        checkCount = 0;
        errorCount = 0;
        buildTable();
        wait (rstN === 1'b1);
        for (int i = 0; i < NumRows; i++) begin
            @(negedge clk);
            applyRow(i);
            #(ClkPeriod / 2 - 1);
            checkRow(i);
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #((NumRows + 10) * ClkPeriod);
        $display("Timeout: the table did not finish within %0d ns",
                 (NumRows + 10) * ClkPeriod);
        $display("Checks failed");
        $finish;
    end

endmodule

/* wakeupPipelineRegister.f */
rtl/recoveryPkg.sv
rtl/schedPkg.sv
rtl/flushWindowTracker.sv
rtl/wakeupLane.sv
rtl/wakeupPipelineRegister.sv
verif/tbClockGen.sv
verif/wakeupPipelineRegisterTb.sv

/* Bender.yml */
package:
  name: wakeupPipelineRegister

sources:
  # Packages first, then the design from the leaves up
  - files:
      - rtl/recoveryPkg.sv
      - rtl/schedPkg.sv
      - rtl/flushWindowTracker.sv
      - rtl/wakeupLane.sv
      - rtl/wakeupPipelineRegister.sv

  - target: test
    files:
      - verif/tbClockGen.sv
      - verif/wakeupPipelineRegisterTb.sv
